/* hw/gc_config_pkg.sv */
// Sizing constants of the global control block
`default_nettype none

package gc_config_pkg;

    //////////////////////////////
    // Exception reporting

    // Units able to report an exception
    localparam int NUM_EXCEPTION_SOURCES = 3;

    // Index of a reporting unit
    localparam int SRC_SEL_WIDTH = 2;

    //////////////////////////////
    // Instruction tracking

    // Instruction ID width, enough for all IDs in flight
    localparam int ID_WIDTH = 3;

    // Most instructions between issue and retire
    localparam int MAX_INFLIGHT = 8;

    //////////////////////////////
    // Start-up

    // Cycles spent clearing per-ID memories after reset
    localparam int INIT_CLEAR_DEPTH = 16;

endpackage

`default_nettype wire

/* hw/gc_types_pkg.sv */
// Instruction encodings, ID and cause code types, and the control state enum
`default_nettype none

package gc_types_pkg;

    import gc_config_pkg::*;

    //////////////////////////////
    // Types

    // Instruction ID as handed out at issue
    typedef logic [ID_WIDTH-1:0] id_t;

    // Trap cause code
    typedef logic [4:0] exception_code_t;

    //////////////////////////////
    // Encodings

    // Upper opcode field, bits [6:2]
    localparam logic [4:0] SYSTEM_T = 5'b11100;
    localparam logic [4:0] FENCE_T = 5'b00011;

    // Immediate field of the return instructions, bits [31:20]
    localparam logic [11:0] MRET_IMM = 12'h302;
    localparam logic [11:0] SRET_IMM = 12'h102;

    // Full encodings with all other fields zero
    localparam logic [31:0] FENCE_I_ENC = 32'h0000_100f;
    localparam logic [31:0] MRET_ENC = 32'h3020_0073;
    localparam logic [31:0] SRET_ENC = 32'h1020_0073;

    //////////////////////////////
    // Control states

    typedef enum logic [2:0] {
        RST_STATE,
        PRE_CLEAR_STATE,
        INIT_CLEAR_STATE,
        IDLE_STATE,
        // Wait for older work before a redirect
        POST_ISSUE_DRAIN,
        // Single flush cycle, PC loaded here
        PRE_ISSUE_FLUSH,
        // Throw away results still in flight
        POST_ISSUE_DISCARD
    } gc_state_t;

endpackage

`default_nettype wire

/* hw/exception_if.sv */
// Exception report bundle of one source with its acknowledge
`timescale 1ns/1ns
`default_nettype none

interface exception_if
    import gc_types_pkg::*;
();

    // Report held until ack is seen
    logic valid;
    exception_code_t code;
    id_t id;
    logic [31:0] tval;

    // Exception taken, source drops valid next edge
    logic ack;

    modport source (output valid, code, id, tval, input ack);
    modport select (input valid, code, id, tval, output ack);

endinterface

`default_nettype wire

/* hw/gc_decode.sv */
// Decode of FENCE.I, MRET and SRET with registered system instruction flags
`timescale 1ns/1ns
`default_nettype none

module gc_decode
    import gc_types_pkg::*;
(
    input logic clk,
    input logic rst,

    // Decode stage
    input logic [31:0] instruction,
    input logic issue_stage_ready,
    output logic unit_needed,
    output logic uses_rs1,

    // Flags of the instruction moving to issue
    output logic is_ifence,
    output logic is_mret,
    output logic is_sret
);

    // Field views of the instruction
    logic [4:0] upper_opcode;
    logic [2:0] fn3;
    logic [11:0] sys_imm;

    assign upper_opcode = instruction[6:2];
    assign fn3 = instruction[14:12];
    assign sys_imm = instruction[31:20];

    // Only the three global control instructions claim this unit
    assign unit_needed = instruction inside {FENCE_I_ENC, MRET_ENC, SRET_ENC};

    // No SFENCE.VMA, so no register source
    assign uses_rs1 = 1'b0;

    // Flags follow the instruction into issue
    always_ff @(posedge clk) begin
        if (rst) begin
            is_ifence <= 1'b0;
            is_mret <= 1'b0;
            is_sret <= 1'b0;
        end else if (issue_stage_ready) begin
            is_ifence <= (upper_opcode == FENCE_T) && (fn3 == 3'b001);
            is_mret <= (upper_opcode == SYSTEM_T) && (sys_imm == MRET_IMM);
            is_sret <= (upper_opcode == SYSTEM_T) && (sys_imm == SRET_IMM);
        end
    end

endmodule

`default_nettype wire

/* hw/inflight_counter.sv */
// Up/down count of instructions between issue and retire
`timescale 1ns/1ns
`default_nettype none

module inflight_counter
    import gc_config_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic issue_pulse,
    input logic retire_pulse,
    output logic inflight_zero
);

    // Holds 0 to MAX_INFLIGHT
    logic [$clog2(MAX_INFLIGHT+1)-1:0] count;

    // Issue and retire together leave the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (issue_pulse && !retire_pulse) begin
            count <= count + 1'b1;
        end else if (retire_pulse && !issue_pulse) begin
            count <= count - 1'b1;
        end
    end

    assign inflight_zero = (count == '0);

endmodule

`default_nettype wire

/* hw/exception_select.sv */
// Oldest instruction exception select and acknowledge across all sources
`timescale 1ns/1ns
`default_nettype none

module exception_select
    import gc_config_pkg::*;
    import gc_types_pkg::*;
(
    exception_if.select exc [NUM_EXCEPTION_SOURCES],

    // Oldest instruction and the unit that owns its exception
    input id_t retire_id,
    input logic [SRC_SEL_WIDTH-1:0] current_exception_unit,

    output logic exception_valid,
    output logic exception_pending,
    output exception_code_t exception_code,
    output logic [31:0] exception_tval
);

    // Flat copies, one slot per selector value
    logic [2**SRC_SEL_WIDTH-1:0] src_valid;
    id_t src_id [2**SRC_SEL_WIDTH];
    exception_code_t src_code [2**SRC_SEL_WIDTH];
    logic [31:0] src_tval [2**SRC_SEL_WIDTH];

    // Interface arrays cannot take a run-time index
    for (genvar i = 0; i < 2**SRC_SEL_WIDTH; i++) begin : g_src
        if (i < NUM_EXCEPTION_SOURCES) begin : g_used
            assign src_valid[i] = exc[i].valid;
            assign src_id[i] = exc[i].id;
            assign src_code[i] = exc[i].code;
            assign src_tval[i] = exc[i].tval;
            assign exc[i].ack = exception_valid;
        end else begin : g_unused
            // Unpopulated selector values never report
            assign src_valid[i] = 1'b0;
            assign src_id[i] = '0;
            assign src_code[i] = '0;
            assign src_tval[i] = '0;
        end
    end

    // Only the owning unit is checked against the oldest ID
    assign exception_valid = src_valid[current_exception_unit]
        && (src_id[current_exception_unit] == retire_id);
    assign exception_code = src_code[current_exception_unit];
    assign exception_tval = src_tval[current_exception_unit];

    // Any report at all, oldest or not
    assign exception_pending = |src_valid;

endmodule

`default_nettype wire

/* hw/gc_fsm.sv */
// Global control FSM with clear counter, registered controls and PC override
`timescale 1ns/1ns
`default_nettype none

module gc_fsm
    import gc_config_pkg::*;
    import gc_types_pkg::*;
(
    input logic clk,
    input logic rst,

    // Issue of a global control instruction
    input logic issue_new_request,
    input logic is_ifence,
    input logic is_mret,
    input logic is_sret,

    // Pipeline and store queue status
    input logic inflight_zero,
    input logic sq_empty,
    input logic no_released_stores_pending,

    // Traps and flushes
    input logic exception_valid,
    input logic exception_pending,
    input logic interrupt_pending,
    input logic branch_flush,

    // Redirect targets
    input logic [31:0] pc_p4,
    input logic [31:0] epc,
    input logic [31:0] exception_target_pc,

    // Core controls
    output logic fetch_hold,
    output logic issue_hold,
    output logic writeback_suppress,
    output logic retire_hold,
    output logic init_clear,
    output logic fetch_flush,
    output logic fetch_ifence,
    output logic pc_override,
    output logic [31:0] pc,
    output logic sq_flush,
    output logic mret,
    output logic sret,
    output logic interrupt_taken
);

    gc_state_t state;
    gc_state_t next_state;

    logic [$clog2(INIT_CLEAR_DEPTH):0] clear_count;
    logic clear_done;

    logic ret_in_progress;
    logic ifence_in_progress;
    logic post_issue_idle;
    logic drain_done;

    // Issue inputs kept for the redirect
    logic [31:0] pc_p4_r;
    logic ifence_r;
    logic mret_r;
    logic sret_r;

    //////////////////////////////
    // Issue capture

    always_ff @(posedge clk) begin
        if (issue_new_request) begin
            pc_p4_r <= pc_p4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifence_r <= 1'b0;
            mret_r <= 1'b0;
            sret_r <= 1'b0;
        end else if (issue_new_request) begin
            ifence_r <= is_ifence;
            mret_r <= is_mret;
            sret_r <= is_sret;
        end
    end

    // Set on issue, cleared once the flush is chosen
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_in_progress <= 1'b0;
            ifence_in_progress <= 1'b0;
        end else begin
            ret_in_progress <= (ret_in_progress && (next_state != PRE_ISSUE_FLUSH))
                || (issue_new_request && (is_mret || is_sret));
            ifence_in_progress <= (ifence_in_progress && (next_state != PRE_ISSUE_FLUSH))
                || (issue_new_request && is_ifence);
        end
    end

    //////////////////////////////
    // State machine

    assign post_issue_idle = inflight_zero && sq_empty;
    assign clear_done = (clear_count == $bits(clear_count)'(INIT_CLEAR_DEPTH));

    // A fence or return waits for a quiet pipeline, interrupts wait for neither
    assign drain_done = exception_valid
        || ((ifence_in_progress || ret_in_progress) ? post_issue_idle : interrupt_pending);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST_STATE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST_STATE: next_state = PRE_CLEAR_STATE;
            PRE_CLEAR_STATE: next_state = INIT_CLEAR_STATE;
            INIT_CLEAR_STATE: if (clear_done) next_state = IDLE_STATE;
            IDLE_STATE: begin
                // Oldest instruction already faulted
                if (exception_valid) begin
                    next_state = PRE_ISSUE_FLUSH;
                end else if (issue_new_request || interrupt_pending || exception_pending) begin
                    next_state = POST_ISSUE_DRAIN;
                end
            end
            POST_ISSUE_DRAIN: if (drain_done) next_state = PRE_ISSUE_FLUSH;
            PRE_ISSUE_FLUSH: next_state = POST_ISSUE_DISCARD;
            POST_ISSUE_DISCARD: begin
                if (inflight_zero && no_released_stores_pending) next_state = IDLE_STATE;
            end
            default: next_state = RST_STATE;
        endcase
    end

    // Counts the cycles spent in INIT_CLEAR
    always_ff @(posedge clk) begin
        if (rst || (next_state == IDLE_STATE)) begin
            clear_count <= '0;
        end else if (next_state == INIT_CLEAR_STATE) begin
            clear_count <= clear_count + 1'b1;
        end
    end

    //////////////////////////////
    // Registered controls

    // Each follows next_state, so it lines up with the state itself
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold <= 1'b0;
            issue_hold <= 1'b0;
            writeback_suppress <= 1'b0;
            retire_hold <= 1'b0;
            init_clear <= 1'b0;
            sq_flush <= 1'b0;
            pc_override <= 1'b0;
        end else begin
            fetch_hold <= next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE,
                POST_ISSUE_DRAIN, PRE_ISSUE_FLUSH};
            issue_hold <= next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE,
                POST_ISSUE_DRAIN, PRE_ISSUE_FLUSH, POST_ISSUE_DISCARD};
            writeback_suppress <= next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE,
                POST_ISSUE_DISCARD};
            retire_hold <= (next_state == PRE_ISSUE_FLUSH);
            init_clear <= (next_state == INIT_CLEAR_STATE);
            // One pulse as discard ends
            sq_flush <= (state == POST_ISSUE_DISCARD) && (next_state == IDLE_STATE);
            // Redirect on flush, plus one pulse entering the clear
            pc_override <= (next_state == PRE_ISSUE_FLUSH) || (state == PRE_CLEAR_STATE);
        end
    end

    //////////////////////////////
    // Redirect

    // Pulses in the deciding cycle
    assign mret = mret_r && ret_in_progress && (next_state == PRE_ISSUE_FLUSH);
    assign sret = sret_r && ret_in_progress && (next_state == PRE_ISSUE_FLUSH);
    assign interrupt_taken = interrupt_pending && (next_state == PRE_ISSUE_FLUSH)
        && !(ifence_in_progress || ret_in_progress || exception_valid);

    // Trap first, then fence, else return
    always_ff @(posedge clk) begin
        if (exception_valid || interrupt_taken) begin
            pc <= exception_target_pc;
        end else if (ifence_r) begin
            pc <= pc_p4_r;
        end else begin
            pc <= epc;
        end
    end

    assign fetch_flush = branch_flush || pc_override;
    assign fetch_ifence = ifence_in_progress;

endmodule

`default_nettype wire

/* hw/gc_top.sv */
// Global control top level with plain ports and the exception source array
`timescale 1ns/1ns
`default_nettype none

module gc_top
    import gc_config_pkg::*;
    import gc_types_pkg::*;
(
    input logic clk,
    input logic rst,

    // Decode and issue
    input logic [31:0] instruction,
    input logic issue_stage_ready,
    input logic issue_new_request,
    input logic issue_pulse,
    input logic retire_pulse,
    output logic unit_needed,
    output logic uses_rs1,

    // Exception sources
    input id_t retire_id,
    input logic [SRC_SEL_WIDTH-1:0] current_exception_unit,
    input logic [NUM_EXCEPTION_SOURCES-1:0] exc_valid,
    input exception_code_t [NUM_EXCEPTION_SOURCES-1:0] exc_code,
    input id_t [NUM_EXCEPTION_SOURCES-1:0] exc_id,
    input logic [NUM_EXCEPTION_SOURCES-1:0][31:0] exc_tval,
    output logic [NUM_EXCEPTION_SOURCES-1:0] exc_ack,
    output logic exception_valid,
    output exception_code_t exception_code,
    output logic [31:0] exception_tval,

    // Core status
    input logic interrupt_pending,
    input logic branch_flush,
    input logic sq_empty,
    input logic no_released_stores_pending,
    input logic [31:0] pc_p4,
    input logic [31:0] epc,
    input logic [31:0] exception_target_pc,

    // Core controls
    output logic fetch_hold,
    output logic issue_hold,
    output logic writeback_suppress,
    output logic retire_hold,
    output logic init_clear,
    output logic fetch_flush,
    output logic fetch_ifence,
    output logic pc_override,
    output logic [31:0] pc,
    output logic sq_flush,
    output logic mret,
    output logic sret,
    output logic interrupt_taken
);

    logic is_ifence;
    logic is_mret;
    logic is_sret;
    logic inflight_zero;
    logic exception_pending;

    exception_if exc_if [NUM_EXCEPTION_SOURCES] ();

    // Source side of each report
    for (genvar i = 0; i < NUM_EXCEPTION_SOURCES; i++) begin : g_exc
        assign exc_if[i].valid = exc_valid[i];
        assign exc_if[i].code = exc_code[i];
        assign exc_if[i].id = exc_id[i];
        assign exc_if[i].tval = exc_tval[i];
        assign exc_ack[i] = exc_if[i].ack;
    end

    gc_decode u_decode (
        .clk (clk),
        .rst (rst),
        .instruction (instruction),
        .issue_stage_ready (issue_stage_ready),
        .unit_needed (unit_needed),
        .uses_rs1 (uses_rs1),
        .is_ifence (is_ifence),
        .is_mret (is_mret),
        .is_sret (is_sret)
    );

    inflight_counter u_inflight (
        .clk (clk),
        .rst (rst),
        .issue_pulse (issue_pulse),
        .retire_pulse (retire_pulse),
        .inflight_zero (inflight_zero)
    );

    exception_select u_exc_select (
        .exc (exc_if),
        .retire_id (retire_id),
        .current_exception_unit (current_exception_unit),
        .exception_valid (exception_valid),
        .exception_pending (exception_pending),
        .exception_code (exception_code),
        .exception_tval (exception_tval)
    );

    gc_fsm u_fsm (
        .clk (clk),
        .rst (rst),
        .issue_new_request (issue_new_request),
        .is_ifence (is_ifence),
        .is_mret (is_mret),
        .is_sret (is_sret),
        .inflight_zero (inflight_zero),
        .sq_empty (sq_empty),
        .no_released_stores_pending (no_released_stores_pending),
        .exception_valid (exception_valid),
        .exception_pending (exception_pending),
        .interrupt_pending (interrupt_pending),
        .branch_flush (branch_flush),
        .pc_p4 (pc_p4),
        .epc (epc),
        .exception_target_pc (exception_target_pc),
        .fetch_hold (fetch_hold),
        .issue_hold (issue_hold),
        .writeback_suppress (writeback_suppress),
        .retire_hold (retire_hold),
        .init_clear (init_clear),
        .fetch_flush (fetch_flush),
        .fetch_ifence (fetch_ifence),
        .pc_override (pc_override),
        .pc (pc),
        .sq_flush (sq_flush),
        .mret (mret),
        .sret (sret),
        .interrupt_taken (interrupt_taken)
    );

endmodule

`default_nettype wire

/* test/gc_assertions.sv */
// Concurrent timing checks on the global control block, bound into gc_top
`timescale 1ns/1ns
`default_nettype none

module gc_assertions
    import gc_config_pkg::*;
    import gc_types_pkg::*;
(
    input logic clk,
    input logic rst,
    input gc_state_t state,
    input logic exception_valid,
    input logic fetch_hold,
    input logic issue_hold,
    input logic writeback_suppress,
    input logic retire_hold,
    input logic init_clear,
    input logic pc_override,
    input logic sq_flush,
    input logic mret,
    input logic sret,
    input logic interrupt_taken
);

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    // Length of the current init_clear run
    int clear_run;

    always_ff @(posedge clk) begin
        if (rst || !init_clear) begin
            clear_run <= 0;
        end else begin
            clear_run <= clear_run + 1;
        end
    end

    //////////////////////////////
    // Reset and clear

    // Quiet controls through reset and one cycle after
    a_reset_quiet: assert property (@(posedge clk) rst |=> !(fetch_hold || issue_hold
        || writeback_suppress || retire_hold || init_clear || pc_override || sq_flush
        || mret || sret || interrupt_taken))
        else begin $error("controls active in reset"); fail_count++; end

    a_clear_length: assert property (@(posedge clk) disable iff (rst)
        $fell(init_clear) |-> clear_run == INIT_CLEAR_DEPTH)
        else begin $error("init_clear run length wrong"); fail_count++; end

    a_clear_holds: assert property (@(posedge clk) disable iff (rst)
        init_clear |-> (fetch_hold && issue_hold && writeback_suppress))
        else begin $error("holds low during clear"); fail_count++; end

    //////////////////////////////
    // Redirect and discard

    // Flush is a single cycle carrying the redirect, discard follows
    a_flush_once: assert property (@(posedge clk) disable iff (rst)
        retire_hold |=> !retire_hold && writeback_suppress && $past(pc_override))
        else begin $error("flush not a single redirect cycle"); fail_count++; end

    a_pulse_redirect: assert property (@(posedge clk) disable iff (rst)
        (mret || sret || interrupt_taken) |=> pc_override)
        else begin $error("no pc_override after return or interrupt"); fail_count++; end

    a_exc_redirect: assert property (@(posedge clk) disable iff (rst)
        exception_valid && (state == IDLE_STATE || state == POST_ISSUE_DRAIN)
        |=> pc_override)
        else begin $error("no pc_override after exception"); fail_count++; end

    // Pulses only as discard ends, so never two cycles running
    a_sq_flush_pulse: assert property (@(posedge clk) disable iff (rst)
        sq_flush |-> $fell(writeback_suppress))
        else begin $error("sq_flush not a single pulse at end of discard"); fail_count++; end

endmodule

bind gc_top gc_assertions u_assert (
    .clk (clk),
    .rst (rst),
    .state (u_fsm.state),
    .exception_valid (exception_valid),
    .fetch_hold (fetch_hold),
    .issue_hold (issue_hold),
    .writeback_suppress (writeback_suppress),
    .retire_hold (retire_hold),
    .init_clear (init_clear),
    .pc_override (pc_override),
    .sq_flush (sq_flush),
    .mret (mret),
    .sret (sret),
    .interrupt_taken (interrupt_taken)
);

`default_nettype wire

/* test/gc_tb.sv */
// Testbench for gc_top with LFSR stimulus, reference checks, error counts and timeout
`timescale 1ns/1ns
`default_nettype none

module gc_tb
    import gc_config_pkg::*;
    import gc_types_pkg::*;
();

    // About 700 cycles of tests, generous margin on top
    localparam int CYCLE_LIMIT = 4000;
    localparam int DECODE_TRIALS = 40;
    localparam int EXC_TRIALS = 60;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] instruction;
    logic issue_stage_ready;
    logic issue_new_request;
    logic issue_pulse;
    logic retire_pulse;
    logic unit_needed;
    logic uses_rs1;
    id_t retire_id;
    logic [SRC_SEL_WIDTH-1:0] current_exception_unit;
    logic [NUM_EXCEPTION_SOURCES-1:0] exc_valid;
    exception_code_t [NUM_EXCEPTION_SOURCES-1:0] exc_code;
    id_t [NUM_EXCEPTION_SOURCES-1:0] exc_id;
    logic [NUM_EXCEPTION_SOURCES-1:0][31:0] exc_tval;
    logic [NUM_EXCEPTION_SOURCES-1:0] exc_ack;
    logic exception_valid;
    exception_code_t exception_code;
    logic [31:0] exception_tval;
    logic interrupt_pending;
    logic branch_flush;
    logic sq_empty;
    logic no_released_stores_pending;
    logic [31:0] pc_p4;
    logic [31:0] epc;
    logic [31:0] exception_target_pc;
    logic fetch_hold;
    logic issue_hold;
    logic writeback_suppress;
    logic retire_hold;
    logic init_clear;
    logic fetch_flush;
    logic fetch_ifence;
    logic pc_override;
    logic [31:0] pc;
    logic sq_flush;
    logic mret;
    logic sret;
    logic interrupt_taken;

    int err_count = 0;
    int cycle_count = 0;
    logic [15:0] lfsr_state = 16'd84;

    gc_top u_dut (.*);

    always #4 clk = ~clk;

    // Hard stop for a hung run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic init_inputs();
        rst = 1'b1;
        instruction = '0;
        issue_stage_ready = 1'b0;
        issue_new_request = 1'b0;
        issue_pulse = 1'b0;
        retire_pulse = 1'b0;
        retire_id = '0;
        current_exception_unit = '0;
        exc_valid = '0;
        exc_code = '0;
        exc_id = '0;
        exc_tval = '0;
        interrupt_pending = 1'b0;
        branch_flush = 1'b0;
        sq_empty = 1'b1;
        no_released_stores_pending = 1'b1;
        pc_p4 = '0;
        epc = '0;
        exception_target_pc = '0;
    endtask

    // Called at a falling edge
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (issue_hold && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (issue_hold) report_problem("Control did not return to idle");
    endtask

    // From the deciding cycle, expect the redirect one cycle later
    task automatic check_redirect(input logic [31:0] exp_pc);
        @(posedge clk);
        #1;
        exc_valid = '0;
        interrupt_pending = 1'b0;
        @(negedge clk);
        check_val("pc_override", pc_override, 1);
        check_val("pc", pc, exp_pc);
        check_val("retire_hold", retire_hold, 1);
        check_val("fetch_flush", fetch_flush, 1);
        check_val("fetch_ifence", fetch_ifence, 0);
    endtask

    // Discard holds while a store or an older instruction is outstanding
    task automatic release_discard(input logic by_retire);
        int waited;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check_val("writeback_suppress", writeback_suppress, 1);
            check_val("sq_flush", sq_flush, 0);
        end
        @(posedge clk);
        #1;
        if (by_retire) begin
            retire_pulse = 1'b1;
        end else begin
            no_released_stores_pending = 1'b1;
        end
        @(posedge clk);
        #1;
        retire_pulse = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!sq_flush && waited < 5);
        if (!sq_flush) report_problem("sq_flush never pulsed after discard");
        check_val("writeback_suppress", writeback_suppress, 0);
        @(negedge clk);
        check_val("sq_flush", sq_flush, 0);
        wait_idle();
    endtask

    //////////////////////////////
    // Tests

    task automatic check_clear();
        int run;
        int waited;
        run = 0;
        waited = 0;
        @(negedge clk);
        check_val("controls", {fetch_hold, issue_hold, writeback_suppress, retire_hold,
            init_clear, pc_override, sq_flush, mret, sret, interrupt_taken}, 0);
        while (!init_clear && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!init_clear) report_problem("init_clear never rose after reset");
        while (init_clear) begin
            check_val("fetch_hold", fetch_hold, 1);
            run++;
            @(negedge clk);
        end
        check_val("init_clear cycles", run, INIT_CLEAR_DEPTH);
        check_val("holds", {fetch_hold, issue_hold, writeback_suppress}, 0);
    endtask

    task automatic check_decode();
        logic [31:0] pick;
        logic [31:0] instr;
        logic [31:0] flush_bit;
        for (int t = 0; t < DECODE_TRIALS; t++) begin
            take_bits(2, pick);
            take_bits(32, instr);
            take_bits(1, flush_bit);
            case (pick[1:0])
                2'd0: instr = FENCE_I_ENC;
                2'd1: instr = MRET_ENC;
                2'd2: instr = SRET_ENC;
                default: ;
            endcase
            @(posedge clk);
            #1;
            instruction = instr;
            // Branch flush reaches fetch directly while idle
            branch_flush = flush_bit[0];
            @(negedge clk);
            check_val("unit_needed", unit_needed,
                instr == FENCE_I_ENC || instr == MRET_ENC || instr == SRET_ENC);
            check_val("uses_rs1", uses_rs1, 0);
            check_val("fetch_flush", fetch_flush, flush_bit[0]);
        end
        @(posedge clk);
        #1;
        branch_flush = 1'b0;
    endtask

    task automatic exception_trial();
        logic [31:0] r;
        logic [1:0] sel;
        logic exp_valid;
        @(posedge clk);
        #1;
        take_bits(2, r);
        sel = r[1:0];
        take_bits(3, r);
        retire_id = id_t'(r);
        for (int s = 0; s < NUM_EXCEPTION_SOURCES; s++) begin
            take_bits(1, r);
            exc_valid[s] = r[0];
            // Half the reports carry the oldest ID
            take_bits(1, r);
            if (r[0]) begin
                exc_id[s] = retire_id;
            end else begin
                take_bits(3, r);
                exc_id[s] = id_t'(r);
            end
            take_bits(5, r);
            exc_code[s] = exception_code_t'(r);
            take_bits(32, r);
            exc_tval[s] = r;
        end
        current_exception_unit = sel;
        take_bits(32, r);
        exception_target_pc = r;
        exp_valid = 1'b0;
        if (sel < NUM_EXCEPTION_SOURCES) begin
            exp_valid = exc_valid[sel] && (exc_id[sel] == retire_id);
        end
        @(negedge clk);
        check_val("exception_valid", exception_valid, exp_valid);
        check_val("exc_ack", exc_ack, {NUM_EXCEPTION_SOURCES{exp_valid}});
        if (sel < NUM_EXCEPTION_SOURCES) begin
            check_val("exception_code", exception_code, exc_code[sel]);
            check_val("exception_tval", exception_tval, exc_tval[sel]);
        end
        if (!exp_valid) begin
            // Oldest-ID report on source 0 ends any drain
            @(posedge clk);
            #1;
            exc_valid = '0;
            exc_valid[0] = 1'b1;
            exc_id[0] = retire_id;
            current_exception_unit = '0;
            @(negedge clk);
            check_val("exception_valid", exception_valid, 1);
        end
        check_redirect(exception_target_pc);
        wait_idle();
    endtask

    // kind 0 FENCE.I, 1 MRET, 2 SRET
    task automatic run_redirect(input logic [31:0] instr, input int kind);
        logic [31:0] r;
        logic [31:0] exp_pc;
        int left;
        // Two older instructions in flight, a store still held
        @(posedge clk);
        #1;
        issue_pulse = 1'b1;
        no_released_stores_pending = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        issue_pulse = 1'b0;
        instruction = instr;
        issue_stage_ready = 1'b1;
        @(posedge clk);
        #1;
        issue_stage_ready = 1'b0;
        issue_new_request = 1'b1;
        take_bits(32, r);
        epc = r;
        take_bits(32, r);
        pc_p4 = r;
        exp_pc = (kind == 0) ? pc_p4 : epc;
        @(posedge clk);
        #1;
        issue_new_request = 1'b0;
        left = 2;
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            check_val("mret", mret, kind == 1 && left == 0);
            check_val("sret", sret, kind == 2 && left == 0);
            check_val("pc_override", pc_override, 0);
            check_val("fetch_ifence", fetch_ifence, kind == 0);
            if (left == 0) break;
            @(posedge clk);
            if (retire_pulse) left--;
            #1;
            retire_pulse = (k >= 2) && (left > 0);
        end
        if (left != 0) report_problem("In-flight work never drained");
        check_redirect(exp_pc);
        // Discard must wait for the held store
        release_discard(1'b0);
    endtask

    task automatic interrupt_trial();
        logic [31:0] r;
        int waited;
        // One older instruction in flight, which an interrupt does not wait for
        @(posedge clk);
        #1;
        issue_pulse = 1'b1;
        @(posedge clk);
        #1;
        issue_pulse = 1'b0;
        take_bits(32, r);
        exception_target_pc = r;
        interrupt_pending = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!interrupt_taken && waited < 10);
        if (!interrupt_taken) report_problem("Interrupt was not taken from idle");
        check_redirect(exception_target_pc);
        // Discard must wait for the older instruction to retire
        release_discard(1'b1);
    endtask

    //////////////////////////////
    // Sequence

    initial begin
        init_inputs();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_clear();
        check_decode();
        repeat (EXC_TRIALS) exception_trial();
        run_redirect(MRET_ENC, 1);
        run_redirect(SRET_ENC, 2);
        run_redirect(FENCE_I_ENC, 0);
        interrupt_trial();
        repeat (2) @(negedge clk);
        $display("Value errors %0d, assertion failures %0d", err_count,
            u_dut.u_assert.fail_count);
        if (err_count == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/gc_config_pkg.sv
hw/gc_types_pkg.sv
hw/exception_if.sv
hw/gc_decode.sv
hw/inflight_counter.sv
hw/exception_select.sv
hw/gc_fsm.sv
hw/gc_top.sv
test/gc_assertions.sv
test/gc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= gc_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
